/* files.f */
src/fir_pkg.sv
src/fir_axil_regs.sv
src/fir_sequencer.sv
src/fir_sat_mac.sv
src/fir.sv
verif/tb_fir.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fir
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_fir.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fir;

    localparam int tap_num   = 11;
    localparam int clk_half  = 20;
    localparam int seed      = 5785;
    localparam int n_samples = 20 + 8 + 24 + 20 + 12;  // Samples over all runs
    localparam int n_reg_ops = 120;
    localparam int timeout_ns = 2 * (n_samples * (tap_num + 10) + n_reg_ops * 10) * 2 * clk_half;
    localparam longint sat_hi = 64'sd2147483647;
    localparam longint sat_lo = -64'sd2147483648;

    logic                       axis_clk;
    logic                       axis_rst_n;
    logic [fir_pkg::addr_w-1:0] awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [fir_pkg::data_w-1:0] wdata;
    logic                       wvalid;
    logic                       wready;
    logic [fir_pkg::addr_w-1:0] araddr;
    logic                       arvalid;
    logic                       arready;
    logic [fir_pkg::data_w-1:0] rdata;
    logic                       rvalid;
    logic                       rready;
    logic [fir_pkg::data_w-1:0] ss_tdata;
    logic                       ss_tvalid;
    logic                       ss_tlast;
    logic                       ss_tready;
    logic [fir_pkg::data_w-1:0] sm_tdata;
    logic                       sm_tvalid;
    logic                       sm_tlast;
    logic                       sm_tready;

    int        coefs [tap_num];
    int        stim_q [$];
    int        got_data [$];
    bit        got_last [$];
    bit        stall_en;
    bit [31:0] rng_state;

    fir #(.tap_num(tap_num)) i_fir (
        .axis_clk, .axis_rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
        .ss_tdata, .ss_tvalid, .ss_tlast, .ss_tready,
        .sm_tdata, .sm_tvalid, .sm_tlast, .sm_tready
    );

    always #clk_half axis_clk = ~axis_clk;

    function automatic bit [31:0] xorshift32();
        bit [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic int clamp32(input longint value);
        if (value > sat_hi) return 32'h7FFF_FFFF;
        if (value < sat_lo) return 32'h8000_0000;
        return int'(value);
    endfunction

    // Expected y[n] with zero history before the run and k = 0 summed first
    function automatic int model_output(input int n);
        longint acc;
        longint x;
        acc = 64'sd0;
        for (int k = 0; k < tap_num; k++) begin
            x = 64'sd0;
            if (n - k >= 0) x = longint'(stim_q[n - k]);
            acc = clamp32(acc + clamp32(x * longint'(coefs[k])));
        end
        return int'(acc);
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_eq(input string what, input int got, input int exp);
        assert (got == exp) else begin
            stop_run($sformatf("FAIL %0t ns: %s is 0x%08h, expected 0x%08h",
                               $time, what, got, exp));
        end
    endtask

    task automatic axil_write(input int addr, input int data);
        @(negedge axis_clk);
        awaddr  = addr[fir_pkg::addr_w-1:0];
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        @(negedge axis_clk);
        while (!awready) @(negedge axis_clk);
        @(negedge axis_clk);
        awvalid = 1'b0;
        while (!wready) @(negedge axis_clk);
        @(negedge axis_clk);
        wvalid = 1'b0;
    endtask

    task automatic axil_read(input int addr, output int data);
        @(negedge axis_clk);
        araddr  = addr[fir_pkg::addr_w-1:0];
        arvalid = 1'b1;
        @(negedge axis_clk);
        while (!arready) @(negedge axis_clk);
        @(negedge axis_clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge axis_clk);
        data   = rdata;
        rready = 1'b1;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic feed_stream();
        for (int i = 0; i < stim_q.size(); i++) begin
            @(negedge axis_clk);
            ss_tdata  = stim_q[i];
            ss_tlast  = (i == stim_q.size() - 1);
            ss_tvalid = 1'b1;
            while (!ss_tready) @(negedge axis_clk);  // Taken at the next rising edge
        end
        @(negedge axis_clk);
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic collect_stream(input int count);
        bit stalled;
        int held_data;
        bit held_last;
        stalled   = 1'b0;
        held_data = 0;
        held_last = 1'b0;
        got_data.delete();
        got_last.delete();
        while (got_data.size() < count) begin
            @(negedge axis_clk);
            if (stalled) begin
                check_eq("sm_tvalid while stalled", int'(sm_tvalid), 1);
                check_eq("sm_tdata while stalled", sm_tdata, held_data);
                check_eq("sm_tlast while stalled", int'(sm_tlast), int'(held_last));
            end
            sm_tready = stall_en ? (xorshift32() % 4 != 0) : 1'b1;
            if (sm_tvalid && sm_tready) begin
                got_data.push_back(sm_tdata);
                got_last.push_back(sm_tlast);
            end
            stalled   = sm_tvalid && !sm_tready;
            held_data = sm_tdata;
            held_last = sm_tlast;
        end
    endtask

    task automatic load_taps();
        for (int k = 0; k < tap_num; k++) begin
            axil_write(int'(fir_pkg::addr_tap_base) + 4 * k, coefs[k]);
        end
    endtask

    // Status polls also clear done, so each run leaves done at 0
    task automatic wait_run_end(output int status);
        status = 0;
        while (status[2] == 1'b0) axil_read(int'(fir_pkg::addr_ap_ctrl), status);
    endtask

    task automatic probe_while_busy();
        int value;
        axil_read(int'(fir_pkg::addr_ap_ctrl), value);
        check_eq("idle bit while running", int'(value[2]), 0);
        axil_read(int'(fir_pkg::addr_tap_base), value);
        check_eq("tap 0 read while running", value, -1);
        axil_write(int'(fir_pkg::addr_tap_base), 32'h0000_1234);  // Must be dropped
    endtask

    task automatic stream_run(input bit probe);
        int status;
        axil_write(int'(fir_pkg::addr_data_length), stim_q.size());
        axil_write(int'(fir_pkg::addr_ap_ctrl), 1);
        fork
            feed_stream();
            collect_stream(stim_q.size());
            begin
                if (probe) probe_while_busy();
            end
        join
        for (int n = 0; n < stim_q.size(); n++) begin
            check_eq($sformatf("output %0d", n), got_data[n], model_output(n));
            check_eq($sformatf("sm_tlast of output %0d", n), int'(got_last[n]),
                     int'(n == stim_q.size() - 1));
        end
        wait_run_end(status);
        check_eq("control after run", status, 32'h6);  // Idle and done
    endtask

    task automatic regs_after_reset();
        int value;
        axil_read(int'(fir_pkg::addr_ap_ctrl), value);
        check_eq("control after reset", value, 32'h4);
        axil_write(int'(fir_pkg::addr_data_length), 20);
        axil_read(int'(fir_pkg::addr_data_length), value);
        check_eq("data_length", value, 20);
        for (int k = 0; k < tap_num; k++) coefs[k] = k * 37 - 150;
        load_taps();
        for (int k = 0; k < tap_num; k++) begin
            axil_read(int'(fir_pkg::addr_tap_base) + 4 * k, value);
            check_eq($sformatf("tap %0d", k), value, coefs[k]);
        end
        axil_read(32'h004, value);
        check_eq("unmapped address 0x004", value, -1);
        axil_read(32'h0FC, value);
        check_eq("tap window beyond tap_num", value, -1);
    endtask

    task automatic basic_filter_run();
        for (int k = 0; k < tap_num; k++) coefs[k] = k - 5;
        stim_q.delete();
        for (int n = 0; n < 20; n++) stim_q.push_back(n * 3 - 17);
        load_taps();
        stream_run(1'b0);
    endtask

    task automatic saturation_run();
        for (int k = 0; k < tap_num; k++) begin
            coefs[k] = (k % 2 == 0) ? 32'h4000_0000 : 32'hC000_0000;
        end
        stim_q = '{32'h7FFF_FFFF, 32'h8000_0000, 32'h0001_0000, 32'h7FFF_FFFF,
                   32'h8000_0000, 32'h1234_5678, 32'h8000_0001, 32'h7FFF_FFFE};
        load_taps();
        stream_run(1'b0);
        // Largest sample times 2^30 overflows upward, the smallest one downward
        check_eq("output 0 at the upper limit", got_data[0], 32'h7FFF_FFFF);
        check_eq("output 1 at the lower limit", got_data[1], 32'h8000_0000);
    endtask

    task automatic back_pressure_run();
        for (int k = 0; k < tap_num; k++) coefs[k] = int'(xorshift32() % 512) - 256;
        stim_q.delete();
        for (int n = 0; n < 24; n++) stim_q.push_back(int'(xorshift32() % 65536) - 32768);
        load_taps();
        stall_en = 1'b1;
        stream_run(1'b0);
        stall_en = 1'b0;
    endtask

    task automatic control_and_status();
        int value;
        for (int k = 0; k < tap_num; k++) coefs[k] = 2 * k + 1;
        stim_q.delete();
        for (int n = 0; n < 20; n++) stim_q.push_back(100 - 7 * n);
        load_taps();
        stream_run(1'b1);
        axil_read(int'(fir_pkg::addr_ap_ctrl), value);
        check_eq("control on second read", value, 32'h4);
        axil_read(int'(fir_pkg::addr_tap_base), value);
        check_eq("tap 0 after write while running", value, coefs[0]);
    endtask

    // Old taps stay loaded, and the model starts from a zero history
    task automatic second_run_after_done();
        stim_q.delete();
        for (int n = 0; n < 12; n++) stim_q.push_back(n * n - 50);
        stream_run(1'b0);
    endtask

    initial begin
        #(timeout_ns);
        $display("Timeout: the tests did not complete within %0d ns", timeout_ns);
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        axis_clk    = 1'b0;
        axis_rst_n  = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        ss_tdata    = '0;
        ss_tvalid   = 1'b0;
        ss_tlast    = 1'b0;
        sm_tready   = 1'b1;
        stall_en    = 1'b0;
        rng_state   = seed;
        repeat (2) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;
        regs_after_reset();
        basic_filter_run();
        saturation_run();
        back_pressure_run();
        control_and_status();
        second_run_after_done();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* src/fir.sv */
`timescale 1ns/1ps
`default_nettype none

module fir #(
    parameter int tap_num = 11
) (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    input  logic [fir_pkg::addr_w-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [fir_pkg::data_w-1:0] wdata,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [fir_pkg::addr_w-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [fir_pkg::data_w-1:0] rdata,
    output logic                       rvalid,
    input  logic                       rready,
    input  logic [fir_pkg::data_w-1:0] ss_tdata,
    input  logic                       ss_tvalid,
    input  logic                       ss_tlast,
    output logic                       ss_tready,
    output logic [fir_pkg::data_w-1:0] sm_tdata,
    output logic                       sm_tvalid,
    output logic                       sm_tlast,
    input  logic                       sm_tready
);
    logic                       start_req;
    logic                       busy;
    logic                       run_done;
    logic [$clog2(tap_num)-1:0] tap_idx;
    fir_pkg::data_t             tap_coef;
    fir_pkg::mac_step_t         step;
    logic                       step_valid;
    logic                       result_taken;

    fir_axil_regs #(.tap_num(tap_num)) i_regs (
        .axis_clk, .axis_rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
        .busy, .run_done, .tap_idx, .start_req, .tap_coef
    );

    fir_sequencer #(.tap_num(tap_num)) i_seq (
        .axis_clk, .axis_rst_n, .start_req,
        .ss_tdata, .ss_tvalid, .ss_tlast, .ss_tready,
        .tap_coef, .tap_idx, .result_taken,
        .step, .step_valid, .busy, .run_done
    );

    fir_sat_mac i_mac (
        .axis_clk, .axis_rst_n, .step, .step_valid,
        .sm_tdata, .sm_tvalid, .sm_tlast, .sm_tready, .result_taken
    );

endmodule

`default_nettype wire

/* src/fir_sat_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_sat_mac (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  fir_pkg::mac_step_t step,
    input  logic               step_valid,
    output fir_pkg::data_t     sm_tdata,
    output logic               sm_tvalid,
    output logic               sm_tlast,
    input  logic               sm_tready,
    output logic               result_taken
);
    typedef logic signed [2*fir_pkg::data_w-1:0] wide_t;

    fir_pkg::data_t prod_q;
    logic           prod_vld;
    logic           prod_first;
    logic           prod_last;
    logic           prod_tlast;
    fir_pkg::data_t acc_q;
    logic           acc_done;   // Accumulator holds a finished sum
    logic           acc_tlast;
    wide_t          prod_full;
    wide_t          sum_full;

    function automatic fir_pkg::data_t saturate(input wide_t value);
        if (value > wide_t'(fir_pkg::data_max)) return fir_pkg::data_max;
        if (value < wide_t'(fir_pkg::data_min)) return fir_pkg::data_min;
        return fir_pkg::data_t'(value);
    endfunction

    assign prod_full    = $signed(step.sample) * $signed(step.coef);
    assign sum_full     = prod_first ? wide_t'(prod_q) : wide_t'(acc_q) + wide_t'(prod_q);
    assign result_taken = sm_tvalid && sm_tready;

    always_ff @(posedge axis_clk) begin
        if (step_valid) begin
            prod_q     <= saturate(prod_full);
            prod_first <= step.first;
            prod_last  <= step.last;
            prod_tlast <= step.tlast;
        end
        if (prod_vld) begin
            acc_q     <= saturate(sum_full);
            acc_tlast <= prod_tlast;
        end
        if (acc_done) sm_tdata <= acc_q;
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            prod_vld  <= 1'b0;
            acc_done  <= 1'b0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else begin
            prod_vld <= step_valid;
            acc_done <= prod_vld && prod_last;
            // Only one result is ever in flight, so a load never meets a pending one
            if (acc_done) begin
                sm_tvalid <= 1'b1;
                sm_tlast  <= acc_tlast;
            end else if (result_taken) begin
                sm_tvalid <= 1'b0;
                sm_tlast  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/fir_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_sequencer #(
    parameter int tap_num = 11
) (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    input  logic                       start_req,
    input  logic [fir_pkg::data_w-1:0] ss_tdata,
    input  logic                       ss_tvalid,
    input  logic                       ss_tlast,
    output logic                       ss_tready,
    input  fir_pkg::data_t             tap_coef,
    output logic [$clog2(tap_num)-1:0] tap_idx,
    input  logic                       result_taken,
    output fir_pkg::mac_step_t         step,
    output logic                       step_valid,
    output logic                       busy,
    output logic                       run_done
);
    localparam int idx_w = $clog2(tap_num);

    typedef logic [idx_w-1:0] idx_t;

    fir_pkg::seq_state_e state;
    fir_pkg::seq_state_e state_nxt;
    fir_pkg::data_t      sample_buf [tap_num];
    idx_t                head;      // Slot of the newest sample
    idx_t                rd_ptr;    // Slot of x[n-k] for the current step
    idx_t                tap_cnt;
    logic                cur_last;
    logic                take;
    logic                last_tap;
    logic                clear_buf;

    assign take       = (state == fir_pkg::seq_fetch) && ss_tvalid;
    assign last_tap   = (tap_cnt == idx_t'(tap_num - 1));
    assign clear_buf  = (state == fir_pkg::seq_idle) && start_req;
    assign ss_tready  = (state == fir_pkg::seq_fetch);
    assign step_valid = (state == fir_pkg::seq_calc);
    assign busy       = (state != fir_pkg::seq_idle);
    assign run_done   = (state == fir_pkg::seq_finish);
    assign tap_idx    = tap_cnt;

    always_comb begin
        step.sample = sample_buf[rd_ptr];
        step.coef   = tap_coef;
        step.first  = (tap_cnt == '0);
        step.last   = last_tap;
        step.tlast  = cur_last;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            fir_pkg::seq_idle: begin
                if (start_req) state_nxt = fir_pkg::seq_fetch;
            end
            fir_pkg::seq_fetch: begin
                if (ss_tvalid) state_nxt = fir_pkg::seq_calc;
            end
            fir_pkg::seq_calc: begin
                if (last_tap) state_nxt = fir_pkg::seq_hold;
            end
            fir_pkg::seq_hold: begin
                if (result_taken) begin
                    state_nxt = cur_last ? fir_pkg::seq_finish : fir_pkg::seq_fetch;
                end
            end
            fir_pkg::seq_finish: state_nxt = fir_pkg::seq_idle;
            default:             state_nxt = fir_pkg::seq_idle;
        endcase
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state    <= fir_pkg::seq_idle;
            head     <= '0;
            rd_ptr   <= '0;
            tap_cnt  <= '0;
            cur_last <= 1'b0;
        end else begin
            state <= state_nxt;
            if (clear_buf) begin
                head <= '0;
            end else if (state == fir_pkg::seq_hold && result_taken) begin
                head <= (head == idx_t'(tap_num - 1)) ? '0 : head + 1'b1;
            end
            if (take) begin
                rd_ptr   <= head;
                cur_last <= ss_tlast;
            end else if (state == fir_pkg::seq_calc) begin
                // Walk back through the history, wrapping at the buffer start
                rd_ptr <= (rd_ptr == '0) ? idx_t'(tap_num - 1) : rd_ptr - 1'b1;
            end
            if (state == fir_pkg::seq_calc) begin
                tap_cnt <= last_tap ? '0 : tap_cnt + 1'b1;
            end
        end
    end

    // History starts from zero on every run
    always_ff @(posedge axis_clk) begin
        if (clear_buf) begin
            for (int i = 0; i < tap_num; i++) begin
                sample_buf[i] <= '0;
            end
        end else if (take) begin
            sample_buf[head] <= ss_tdata;
        end
    end

endmodule

`default_nettype wire

/* src/fir_axil_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_axil_regs #(
    parameter int tap_num = 11
) (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    input  logic [fir_pkg::addr_w-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [fir_pkg::data_w-1:0] wdata,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [fir_pkg::addr_w-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [fir_pkg::data_w-1:0] rdata,
    output logic                       rvalid,
    input  logic                       rready,
    input  logic                       busy,
    input  logic                       run_done,
    input  logic [$clog2(tap_num)-1:0] tap_idx,
    output logic                       start_req,
    output fir_pkg::data_t             tap_coef
);
    localparam int idx_w = $clog2(tap_num);

    fir_pkg::axil_wr_state_e    wr_state;
    fir_pkg::axil_wr_state_e    wr_state_nxt;
    fir_pkg::axil_rd_state_e    rd_state;
    fir_pkg::axil_rd_state_e    rd_state_nxt;
    fir_pkg::addr_t             awaddr_q;
    fir_pkg::addr_t             araddr_q;
    logic                       start_q;
    logic                       done_q;
    logic                       idle_q;
    logic [fir_pkg::data_w-1:0] data_length;
    fir_pkg::data_t             taps [tap_num];
    logic                       wr_en;
    logic                       wr_tap_hit;
    logic                       rd_tap_hit;
    logic [fir_pkg::data_w-1:0] rd_word;

    // Inside the tap window and below tap_num words
    function automatic logic is_tap(input fir_pkg::addr_t addr);
        fir_pkg::addr_t word;
        word = (addr - fir_pkg::addr_tap_base) >> 2;
        return (addr >= fir_pkg::addr_tap_base) && (addr <= fir_pkg::addr_tap_last) &&
               (word < tap_num);
    endfunction

    function automatic logic [idx_w-1:0] tap_word(input fir_pkg::addr_t addr);
        fir_pkg::addr_t word;
        word = (addr - fir_pkg::addr_tap_base) >> 2;
        return word[idx_w-1:0];
    endfunction

    assign wr_en      = (wr_state == fir_pkg::wr_data);
    assign awready    = (wr_state == fir_pkg::wr_addr);
    assign wready     = wr_en;  // Master holds wdata until this cycle
    assign arready    = (rd_state == fir_pkg::rd_addr);
    assign rvalid     = (rd_state == fir_pkg::rd_respond);
    assign wr_tap_hit = is_tap(awaddr_q);
    assign rd_tap_hit = is_tap(araddr_q);
    assign start_req  = wr_en && (awaddr_q == fir_pkg::addr_ap_ctrl) && wdata[0] && idle_q;
    assign tap_coef   = taps[tap_idx];

    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            fir_pkg::wr_idle:      if (awvalid) wr_state_nxt = fir_pkg::wr_addr;
            fir_pkg::wr_addr:      wr_state_nxt = fir_pkg::wr_wait_data;
            fir_pkg::wr_wait_data: if (wvalid) wr_state_nxt = fir_pkg::wr_data;
            fir_pkg::wr_data:      wr_state_nxt = fir_pkg::wr_idle;
            default:               wr_state_nxt = fir_pkg::wr_idle;
        endcase
    end

    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            fir_pkg::rd_idle:    if (arvalid) rd_state_nxt = fir_pkg::rd_addr;
            fir_pkg::rd_addr:    rd_state_nxt = fir_pkg::rd_respond;
            fir_pkg::rd_respond: if (rready) rd_state_nxt = fir_pkg::rd_done;
            fir_pkg::rd_done:    rd_state_nxt = fir_pkg::rd_idle;
            default:             rd_state_nxt = fir_pkg::rd_idle;
        endcase
    end

    always_comb begin
        if (rd_tap_hit) begin
            rd_word = busy ? '1 : taps[tap_word(araddr_q)];  // Taps hidden while running
        end else if (araddr_q == fir_pkg::addr_ap_ctrl) begin
            rd_word = {{(fir_pkg::data_w-3){1'b0}}, idle_q, done_q, start_q};
        end else if (araddr_q == fir_pkg::addr_data_length) begin
            rd_word = data_length;
        end else begin
            rd_word = '1;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            wr_state    <= fir_pkg::wr_idle;
            rd_state    <= fir_pkg::rd_idle;
            start_q     <= 1'b0;
            done_q      <= 1'b0;
            idle_q      <= 1'b1;
            data_length <= '0;
        end else begin
            wr_state <= wr_state_nxt;
            rd_state <= rd_state_nxt;
            if (start_req) begin
                start_q <= 1'b1;
            end else if (busy) begin
                start_q <= 1'b0;  // Sequencer has taken the run
            end
            if (start_req) begin
                idle_q <= 1'b0;
            end else if (run_done) begin
                idle_q <= 1'b1;
            end
            if (run_done) begin
                done_q <= 1'b1;
            end else if (rd_state == fir_pkg::rd_done && araddr_q == fir_pkg::addr_ap_ctrl) begin
                done_q <= 1'b0;  // Cleared once the status read completes
            end
            if (wr_en && !busy && awaddr_q == fir_pkg::addr_data_length) begin
                data_length <= wdata;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_state == fir_pkg::wr_idle && awvalid) awaddr_q <= awaddr;
        if (rd_state == fir_pkg::rd_idle && arvalid) araddr_q <= araddr;
        if (rd_state == fir_pkg::rd_addr) rdata <= rd_word;
        if (wr_en && !busy && wr_tap_hit) begin
            taps[tap_word(awaddr_q)] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* src/fir_pkg.sv */
`default_nettype none

package fir_pkg;

    localparam int data_w = 32;
    localparam int addr_w = 12;

    typedef logic signed [data_w-1:0] data_t;
    typedef logic [addr_w-1:0]        addr_t;

    // Register map of the AXI-Lite slave
    localparam addr_t addr_ap_ctrl     = 12'h000;
    localparam addr_t addr_data_length = 12'h010;
    localparam addr_t addr_tap_base    = 12'h020;  // One coefficient per word
    localparam addr_t addr_tap_last    = 12'h0FF;

    localparam data_t data_max = 32'sh7FFF_FFFF;
    localparam data_t data_min = 32'sh8000_0000;

    typedef enum logic [2:0] {
        seq_idle,
        seq_fetch,
        seq_calc,
        seq_hold,
        seq_finish
    } seq_state_e;

    typedef enum logic [1:0] {
        wr_idle,
        wr_addr,
        wr_wait_data,
        wr_data
    } axil_wr_state_e;

    typedef enum logic [1:0] {
        rd_idle,
        rd_addr,
        rd_respond,
        rd_done
    } axil_rd_state_e;

    // One multiply-accumulate term
    typedef struct packed {
        data_t sample;
        data_t coef;
        logic  first;   // Starts a new sum
        logic  last;    // Closes the sum
        logic  tlast;   // Sum belongs to the final sample of the run
    } mac_step_t;

endpackage

`default_nettype wire
